/* ahb_sram_pkg.sv */
// AHB SRAM shared definitions
package ahb_sram_pkg;

   // Byte address width of the slave window
   localparam int ADDR_W = 12;

   // Word address width, bits 1:0 select the byte lane
   localparam int WORD_AW = ADDR_W - 2;

   // Number of words in the bank
   localparam int MEM_WORDS = 2 ** WORD_AW;

   // Bus and SRAM data width
   localparam int DATA_W = 32;

   // Byte lanes per word
   localparam int NUM_LANES = 4;

   // Bits per lane
   localparam int LANE_W = DATA_W / NUM_LANES;

   // AHB transfer type
   typedef enum logic [1:0] {
      // No transfer requested
      HTRANS_IDLE   = 2'b00,
      // Master inserts a gap inside a burst
      HTRANS_BUSY   = 2'b01,
      // First beat or single transfer
      HTRANS_NONSEQ = 2'b10,
      // Following beat of a burst
      HTRANS_SEQ    = 2'b11
   } htrans_e;

   // AHB transfer size
   typedef enum logic [2:0] {
      // 8 bits, one lane
      HSIZE_BYTE = 3'b000,
      // 16 bits, lane pair picked by address bit 1
      HSIZE_HALF = 3'b001,
      // 32 bits, all lanes
      HSIZE_WORD = 3'b010
   } hsize_e;

endpackage

/* ahb_ssram_chk.sv */
// Bridge strobe and ready assertions
`timescale 1ns/1ps

module ahb_ssram_chk (
   input  logic                                HCLK,
   input  logic                                HRESETn,
   input  logic                                HREADYOUT,
   input  logic                                HRESP,
   input  logic                                sram_en,
   input  logic                                sram_we,
   input  logic [ahb_sram_pkg::NUM_LANES-1:0]  sram_wb
);

   // Count of assertion failures
   int fail_cnt = 0;

   // Write level only inside an access
   we_implies_en: assert property (
      @(posedge HCLK) disable iff (!HRESETn) sram_we |-> sram_en
   ) else begin
      $error("sram_we high while sram_en low");
      fail_cnt++;
   end

   // No lane strobes on reads or idle cycles
   wb_only_on_write: assert property (
      @(posedge HCLK) disable iff (!HRESETn) !sram_we |-> (sram_wb == '0)
   ) else begin
      $error("sram_wb nonzero while sram_we low");
      fail_cnt++;
   end

   // At most one wait state
   single_wait: assert property (
      @(posedge HCLK) disable iff (!HRESETn) !HREADYOUT |=> HREADYOUT
   ) else begin
      $error("HREADYOUT low for two cycles in a row");
      fail_cnt++;
   end

   // Always OKAY
   resp_okay: assert property (
      @(posedge HCLK) disable iff (!HRESETn) HRESP == 1'b0
   ) else begin
      $error("HRESP not OKAY");
      fail_cnt++;
   end

endmodule

bind ahb_to_ssram ahb_ssram_chk u_chk (
   .HCLK      (HCLK),
   .HRESETn   (HRESETn),
   .HREADYOUT (HREADYOUT),
   .HRESP     (HRESP),
   .sram_en   (sram_en),
   .sram_we   (sram_we),
   .sram_wb   (sram_wb)
);

/* ahb_ssram_top.sv */
// AHB SRAM slave top level
`timescale 1ns/1ps

module ahb_ssram_top (
   input  logic                             HCLK,
   input  logic                             HRESETn,
   input  logic                             HSEL,
   input  logic [ahb_sram_pkg::ADDR_W-1:0]  HADDR,
   input  ahb_sram_pkg::htrans_e            HTRANS,
   input  ahb_sram_pkg::hsize_e             HSIZE,
   input  logic                             HWRITE,
   input  logic [ahb_sram_pkg::DATA_W-1:0]  HWDATA,
   output logic [ahb_sram_pkg::DATA_W-1:0]  HRDATA,
   output logic                             HREADY,
   output logic                             HRESP
);

   import ahb_sram_pkg::*;

   // Bridge to bank strobes
   logic [WORD_AW-1:0]   sram_addr;
   logic                 sram_en;
   logic                 sram_we;
   logic [NUM_LANES-1:0] sram_wb;
   logic [DATA_W-1:0]    sram_din;
   logic [DATA_W-1:0]    sram_dout;

   // Only slave on the bus, so its ready is the bus ready
   ahb_to_ssram u_bridge (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .HSEL      (HSEL),
      .HADDR     (HADDR),
      .HTRANS    (HTRANS),
      .HSIZE     (HSIZE),
      .HWRITE    (HWRITE),
      .HWDATA    (HWDATA),
      .HREADY    (HREADY),
      .sram_dout (sram_dout),
      .HREADYOUT (HREADY),
      .HRDATA    (HRDATA),
      .HRESP     (HRESP),
      .sram_addr (sram_addr),
      .sram_en   (sram_en),
      .sram_we   (sram_we),
      .sram_wb   (sram_wb),
      .sram_din  (sram_din)
   );

   // Memory array
   ssram_bank u_bank (
      .HCLK      (HCLK),
      .sram_addr (sram_addr),
      .sram_en   (sram_en),
      .sram_we   (sram_we),
      .sram_wb   (sram_wb),
      .sram_din  (sram_din),
      .sram_dout (sram_dout)
   );

endmodule

/* ahb_to_ssram.sv */
// AHB-Lite to synchronous SRAM bridge
`timescale 1ns/1ps

module ahb_to_ssram (
   input  logic                                HCLK,
   input  logic                                HRESETn,
   input  logic                                HSEL,
   input  logic [ahb_sram_pkg::ADDR_W-1:0]     HADDR,
   input  ahb_sram_pkg::htrans_e               HTRANS,
   input  ahb_sram_pkg::hsize_e                HSIZE,
   input  logic                                HWRITE,
   input  logic [ahb_sram_pkg::DATA_W-1:0]     HWDATA,
   input  logic                                HREADY,
   input  logic [ahb_sram_pkg::DATA_W-1:0]     sram_dout,
   output logic                                HREADYOUT,
   output logic [ahb_sram_pkg::DATA_W-1:0]     HRDATA,
   output logic                                HRESP,
   output logic [ahb_sram_pkg::WORD_AW-1:0]    sram_addr,
   output logic                                sram_en,
   output logic                                sram_we,
   output logic [ahb_sram_pkg::NUM_LANES-1:0]  sram_wb,
   output logic [ahb_sram_pkg::DATA_W-1:0]     sram_din
);

   import ahb_sram_pkg::*;

   // Live address phase decode
   logic                 active_trans;
   logic                 trans_valid;
   logic                 read_valid;
   logic                 write_valid;
   logic [NUM_LANES-1:0] byte_sel;

   // Registered address phase
   logic                 wr_pend_r;
   logic [WORD_AW-1:0]   addr_r;
   logic [NUM_LANES-1:0] lanes_r;

   // Stall cycle, SRAM replays the held read
   logic                 stall;

   // Transfer type
   always_comb begin
      unique case (HTRANS)
         HTRANS_NONSEQ: active_trans = 1'b1;
         HTRANS_SEQ:    active_trans = 1'b1;
         // BUSY behaves like IDLE here
         HTRANS_BUSY:   active_trans = 1'b0;
         HTRANS_IDLE:   active_trans = 1'b0;
         default:       active_trans = 1'b0;
      endcase
   end

   // Accepted only with the slave selected and the bus ready
   assign trans_valid = active_trans & HSEL & HREADY;
   assign read_valid  = trans_valid & ~HWRITE;
   assign write_valid = trans_valid & HWRITE;

   // Byte lanes from size and low address bits
   always_comb begin
      case (HSIZE)
         HSIZE_BYTE: begin
            case (HADDR[1:0])
               2'd0:    byte_sel = 4'b0001;
               2'd1:    byte_sel = 4'b0010;
               2'd2:    byte_sel = 4'b0100;
               default: byte_sel = 4'b1000;
            endcase
         end
         // Low or high pair
         HSIZE_HALF: byte_sel = HADDR[1] ? 4'b1100 : 4'b0011;
         HSIZE_WORD: byte_sel = 4'b1111;
         // Wider sizes not supported, take the full word
         default:    byte_sel = 4'b1111;
      endcase
   end

   // Pending write flag, set for the data phase of an accepted write
   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         wr_pend_r <= 1'b0;
      end else if (HREADY) begin
         wr_pend_r <= write_valid;
      end
   end

   // Address and lanes held through the data phase
   always_ff @(posedge HCLK) begin
      if (HREADY) begin
         addr_r  <= HADDR[ADDR_W-1:2];
         lanes_r <= byte_sel;
      end
   end

   // One wait state when a read lands on a write data phase
   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         HREADYOUT <= 1'b1;
      end else begin
         HREADYOUT <= ~(wr_pend_r & read_valid);
      end
   end

   assign stall = ~HREADYOUT;

   // Registered address for the write commit and the replayed read
   assign sram_addr = (wr_pend_r | stall) ? addr_r : HADDR[ADDR_W-1:2];

   // Live read, write commit or read replay
   assign sram_en = read_valid | wr_pend_r | stall;
   assign sram_we = wr_pend_r;

   // Lane strobes only while committing a write
   assign sram_wb = lanes_r & {NUM_LANES{wr_pend_r}};

   // Write data arrives in the data phase, same cycle as the commit
   assign sram_din = HWDATA;

   // Read data straight from the bank register
   assign HRDATA = sram_dout;

   // Always OKAY
   assign HRESP = 1'b0;

endmodule

/* files.f */
ahb_sram_pkg.sv
ahb_to_ssram.sv
ssram_bank.sv
ahb_ssram_top.sv
ahb_ssram_chk.sv
tb_ahb_ssram.sv

/* ssram_bank.sv */
// Synchronous single-port SRAM bank
`timescale 1ns/1ps

module ssram_bank (
   input  logic                                HCLK,
   input  logic [ahb_sram_pkg::WORD_AW-1:0]    sram_addr,
   input  logic                                sram_en,
   input  logic                                sram_we,
   input  logic [ahb_sram_pkg::NUM_LANES-1:0]  sram_wb,
   input  logic [ahb_sram_pkg::DATA_W-1:0]     sram_din,
   output logic [ahb_sram_pkg::DATA_W-1:0]     sram_dout
);

   import ahb_sram_pkg::*;

   // Word storage, contents undefined until written
   logic [DATA_W-1:0] mem [MEM_WORDS];

   // Write port with per-lane masking
   always_ff @(posedge HCLK) begin
      if (sram_en && sram_we) begin
         for (int i = 0; i < NUM_LANES; i++) begin
            // Untouched lanes keep their old byte
            if (sram_wb[i]) begin
               mem[sram_addr][i*LANE_W +: LANE_W] <= sram_din[i*LANE_W +: LANE_W];
            end
         end
      end
   end

   // Read port, one cycle latency
   always_ff @(posedge HCLK) begin
      if (sram_en && !sram_we) begin
         sram_dout <= mem[sram_addr];
      end
      // Output holds while the bank is idle or writing
   end

endmodule

/* tb_ahb_ssram.sv */
// AHB SRAM slave testbench
`timescale 1ns/1ps

module tb_ahb_ssram;

   import ahb_sram_pkg::*;

   // 64-word test window from byte 0x400
   localparam int WIN_WORDS = 64;
   localparam logic [ADDR_W-1:0] WIN_BASE = 12'h400;

   // Phase lengths
   localparam int N_SUB  = 100;
   localparam int N_RAW  = 50;
   localparam int N_IDLE = 50;
   localparam int N_RAND = 2000;

   // Every issued address phase including two flush cycles
   localparam int TOTAL_XFERS = 2 * WIN_WORDS + (N_SUB + WIN_WORDS) + 2 * N_RAW
                                + (N_IDLE + WIN_WORDS) + N_RAND + 2;
   localparam int TIMEOUT_CYC = 3 * TOTAL_XFERS + 100;
   localparam logic [31:0] SEED = 32'ha8dfb6c9;

   // DUT ports
   logic              HCLK;
   logic              HRESETn;
   logic              HSEL;
   logic [ADDR_W-1:0] HADDR;
   htrans_e           HTRANS;
   hsize_e            HSIZE;
   logic              HWRITE;
   logic [DATA_W-1:0] HWDATA;
   logic [DATA_W-1:0] HRDATA;
   logic              HREADY;
   logic              HRESP;

   // Reference memory of the whole bank
   logic [DATA_W-1:0] model [MEM_WORDS];

   // Address phase on the bus
   logic              ap_valid;
   logic              ap_write;
   logic [ADDR_W-1:0] ap_addr;
   hsize_e            ap_size;
   logic [DATA_W-1:0] ap_data;

   // Data phase in flight
   logic              dp_valid;
   logic              dp_write;
   logic [ADDR_W-1:0] dp_addr;
   hsize_e            dp_size;
   logic [DATA_W-1:0] dp_data;
   // Read landing on a write data phase takes one wait state
   logic              dp_stall;

   int cycle_cnt = 0;

   ahb_ssram_top UUT (
      .HCLK    (HCLK),
      .HRESETn (HRESETn),
      .HSEL    (HSEL),
      .HADDR   (HADDR),
      .HTRANS  (HTRANS),
      .HSIZE   (HSIZE),
      .HWRITE  (HWRITE),
      .HWDATA  (HWDATA),
      .HRDATA  (HRDATA),
      .HREADY  (HREADY),
      .HRESP   (HRESP)
   );

   // 10 ns clock
   always #5 HCLK = ~HCLK;

   // Run limit and bridge assertion watch
   always @(posedge HCLK) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYC) begin
         $display("Timeout, run still going after %0d cycles", cycle_cnt);
         $display("sim failed");
         $fatal(1);
      end else if (UUT.u_bridge.u_chk.fail_cnt != 0) begin
         $display("Bridge assertion failed before cycle %0d", cycle_cnt);
         $display("sim failed");
         $fatal(1);
      end
   end

   task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
      if (act !== exp) begin
         $display("ERR %s exp=0x%h act=0x%h", name, exp, act);
         $display("sim failed");
         $fatal(1);
      end
   endtask

   task automatic check_ready(input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR HREADY exp=0x%h act=0x%h", exp, act);
         $display("sim failed");
         $fatal(1);
      end
   endtask

   task automatic check_resp(input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR HRESP exp=0x%h act=0x%h", exp, act);
         $display("sim failed");
         $fatal(1);
      end
   endtask

   // Lanes touched are 2**size bytes from the byte offset
   function automatic logic [NUM_LANES-1:0] lane_mask(input hsize_e size,
                                                      input logic [1:0] offs);
      int nbytes;
      nbytes = 1 << size;
      return NUM_LANES'(((1 << nbytes) - 1) << offs);
   endfunction

   task automatic model_write(input logic [ADDR_W-1:0] addr, input hsize_e size,
                              input logic [DATA_W-1:0] data);
      logic [NUM_LANES-1:0] mask;
      mask = lane_mask(size, addr[1:0]);
      for (int i = 0; i < NUM_LANES; i++) begin
         if (mask[i]) begin
            model[addr[ADDR_W-1:2]][i*LANE_W +: LANE_W] = data[i*LANE_W +: LANE_W];
         end
      end
   endtask

   function automatic hsize_e rand_size();
      case ($urandom_range(0, 2))
         0:       return HSIZE_BYTE;
         1:       return HSIZE_HALF;
         default: return HSIZE_WORD;
      endcase
   endfunction

   // Random size-aligned byte address in the window
   function automatic logic [ADDR_W-1:0] rand_addr(input hsize_e size);
      logic [ADDR_W-1:0] offs;
      offs = ADDR_W'($urandom_range(0, 4 * WIN_WORDS - 1));
      offs = offs & ~((ADDR_W'(1) << size) - 1);
      return WIN_BASE + offs;
   endfunction

   // One address phase held until HREADY is seen high
   task automatic issue(input logic sel, input htrans_e trans, input logic write,
                        input hsize_e size, input logic [ADDR_W-1:0] addr,
                        input logic [DATA_W-1:0] data);
      logic              ready_s;
      logic [DATA_W-1:0] rdata_s;
      int                waits;
      waits   = 0;
      ready_s = 1'b0;
      while (!ready_s) begin
         // Outputs are stable at the falling edge
         @(negedge HCLK);
         ready_s = HREADY;
         rdata_s = HRDATA;
         check_resp(1'b0, HRESP);
         check_ready(!(dp_stall && waits == 0), ready_s);
         waits++;
         @(posedge HCLK);
      end
      // Data phase completes at this edge
      if (dp_valid && dp_write) begin
         model_write(dp_addr, dp_size, dp_data);
      end else if (dp_valid) begin
         check_word("HRDATA", model[dp_addr[ADDR_W-1:2]], rdata_s);
      end
      // Address phase on the bus becomes the data phase
      dp_stall = ap_valid && !ap_write && dp_valid && dp_write;
      dp_valid = ap_valid;
      dp_write = ap_write;
      dp_addr  = ap_addr;
      dp_size  = ap_size;
      dp_data  = ap_data;
      HWDATA  <= ap_data;
      // Next address phase
      HSEL     <= sel;
      HADDR    <= addr;
      HTRANS   <= trans;
      HSIZE    <= size;
      HWRITE   <= write;
      ap_valid = sel && (trans == HTRANS_NONSEQ || trans == HTRANS_SEQ);
      ap_write = write;
      ap_addr  = addr;
      ap_size  = size;
      ap_data  = data;
   endtask

   task automatic read_window();
      for (int i = 0; i < WIN_WORDS; i++) begin
         issue(1'b1, (i == 0) ? HTRANS_NONSEQ : HTRANS_SEQ, 1'b0, HSIZE_WORD,
               WIN_BASE + ADDR_W'(4 * i), '0);
      end
   endtask

   initial begin
      int                kind;
      hsize_e            sz;
      logic [ADDR_W-1:0] a;
      void'($urandom(SEED));
      HCLK     = 1'b0;
      HRESETn  = 1'b0;
      HSEL     = 1'b0;
      HADDR    = '0;
      HTRANS   = HTRANS_IDLE;
      HSIZE    = HSIZE_WORD;
      HWRITE   = 1'b0;
      HWDATA   = '0;
      ap_valid = 1'b0;
      ap_write = 1'b0;
      ap_addr  = '0;
      ap_size  = HSIZE_WORD;
      ap_data  = '0;
      dp_valid = 1'b0;
      dp_write = 1'b0;
      dp_addr  = '0;
      dp_size  = HSIZE_WORD;
      dp_data  = '0;
      dp_stall = 1'b0;

      // Reset state during and just after reset
      repeat (2) begin
         @(negedge HCLK);
         check_ready(1'b1, HREADY);
         check_resp(1'b0, HRESP);
      end
      @(posedge HCLK);
      HRESETn <= 1'b1;
      @(negedge HCLK);
      check_ready(1'b1, HREADY);
      check_resp(1'b0, HRESP);
      @(posedge HCLK);

      // Word fill of the window and read back
      for (int i = 0; i < WIN_WORDS; i++) begin
         issue(1'b1, (i == 0) ? HTRANS_NONSEQ : HTRANS_SEQ, 1'b1, HSIZE_WORD,
               WIN_BASE + ADDR_W'(4 * i), $urandom);
      end
      read_window();

      // Byte and halfword lanes
      for (int i = 0; i < N_SUB; i++) begin
         sz = rand_size();
         issue(1'b1, HTRANS_NONSEQ, 1'b1, sz, rand_addr(sz), $urandom);
      end
      read_window();

      // Read straight after write to the same word
      for (int i = 0; i < N_RAW; i++) begin
         sz = rand_size();
         a  = rand_addr(sz);
         issue(1'b1, HTRANS_NONSEQ, 1'b1, sz, a, $urandom);
         issue(1'b1, HTRANS_NONSEQ, 1'b0, HSIZE_WORD, {a[ADDR_W-1:2], 2'b00}, '0);
      end

      // Writes that must not land
      for (int i = 0; i < N_IDLE; i++) begin
         kind = $urandom_range(0, 2);
         a    = rand_addr(HSIZE_WORD);
         if (kind == 0) begin
            issue(1'b1, HTRANS_IDLE, 1'b1, HSIZE_WORD, a, $urandom);
         end else if (kind == 1) begin
            issue(1'b1, HTRANS_BUSY, 1'b1, HSIZE_WORD, a, $urandom);
         end else begin
            issue(1'b0, HTRANS_NONSEQ, 1'b1, HSIZE_WORD, a, $urandom);
         end
      end
      read_window();

      // Mixed traffic
      for (int i = 0; i < N_RAND; i++) begin
         kind = $urandom_range(0, 9);
         sz   = rand_size();
         a    = rand_addr(sz);
         if (kind == 0) begin
            issue(1'b1, HTRANS_IDLE, 1'b0, sz, a, $urandom);
         end else if (kind < 5) begin
            issue(1'b1, ($urandom_range(0, 1) != 0) ? HTRANS_SEQ : HTRANS_NONSEQ,
                  1'b1, sz, a, $urandom);
         end else begin
            issue(1'b1, ($urandom_range(0, 1) != 0) ? HTRANS_SEQ : HTRANS_NONSEQ,
                  1'b0, sz, a, '0);
         end
      end

      // Drain the pipeline
      issue(1'b0, HTRANS_IDLE, 1'b0, HSIZE_WORD, '0, '0);
      issue(1'b0, HTRANS_IDLE, 1'b0, HSIZE_WORD, '0, '0);

      if (UUT.u_bridge.u_chk.fail_cnt == 0) begin
         $display("sim passed");
         $finish;
      end else begin
         $display("Bridge assertions failed %0d times", UUT.u_bridge.u_chk.fail_cnt);
         $display("sim failed");
         $fatal(1);
      end
   end

endmodule
